// File: src/bus_pkg.sv
////////////////////////////////////////
//
// processor bus package
// unit codes, microinstruction layout and
// the active-low control line bundles
//
////////////////////////////////////////

package bus_pkg;

   // width of the IR offset placed below the PC page bits
   localparam int AGL_OFFSET_W = 10;

   // read unit codes
   // 6 and 7 are unused, 8 to 15 belong to the ALU
   typedef enum logic [3:0] {
      RU_IDLE = 4'd0,
      RU_EXT  = 4'd1,
      RU_AGL  = 4'd2,
      RU_PC   = 4'd3,
      RU_DR   = 4'd4,
      RU_AC   = 4'd5
   } runit_e;

   // write unit codes, 0 and 1 are unused
   typedef enum logic [2:0] {
      WU_AR  = 3'd2,
      WU_PC  = 3'd3,
      WU_IR  = 3'd4,
      WU_DR  = 3'd5,
      WU_AC  = 3'd6,
      WU_ALU = 3'd7
   } wunit_e;

   // alu operations, same bits as the low part of read codes 8 to 15
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_NOT = 3'd5,
      OP_SHL = 3'd6,
      OP_SHR = 3'd7
   } alu_op_e;

   // read field seen by the unit decoder
   typedef struct packed {
      logic       zero;
      logic [2:0] sel;
   } read_unit_t;

   // read field seen by the alu
   typedef struct packed {
      logic    alu;
      alu_op_e op;
   } read_alu_t;

   // one read field, two decodings
   typedef union packed {
      read_unit_t unit;
      read_alu_t  alu;
   } read_field_u;

   typedef struct packed {
      read_field_u rd;
      wunit_e      wr;
   } micro_t;

   // active-low read enables, next is the external port
   typedef struct packed {
      logic next;
      logic nragl;
      logic nrpc;
      logic nrdr;
      logic nrac;
   } read_lines_t;

   // active-low write strobes
   typedef struct packed {
      logic nwar;
      logic nwpc;
      logic nwir;
      logic nwdr;
      logic nwac;
      logic nwalu;
   } write_lines_t;

   // every line inactive
   localparam read_lines_t  RLINES_OFF = '1;
   localparam write_lines_t WLINES_OFF = '1;

endpackage

// File: src/unit_decoder.sv
////////////////////////////////////////
//
// unit decoder
// turns the read and write unit fields into
// active-low enables, all high in reset or
// while the unit control enable is off
//
////////////////////////////////////////

module unit_decoder
   import bus_pkg::*;
(
   input  logic         clk5,
   input  logic         rst_n,
   input  logic         nuce,
   input  micro_t       ucode,
   output read_lines_t  rlines,
   output write_lines_t wlines
);

   // lines may only be driven when out of reset and enabled
   logic lines_on;

   assign lines_on = rst_n && !nuce;

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////

   // only the lower half of the codes is decoded here
   // the upper half is picked up by the alu through its own view
   always_comb begin
      rlines = RLINES_OFF;
      if (lines_on && !ucode.rd.unit.zero) begin
         case (runit_e'({1'b0, ucode.rd.unit.sel}))
            RU_IDLE: rlines = RLINES_OFF;
            RU_EXT:  rlines.next  = 1'b0;
            RU_AGL:  rlines.nragl = 1'b0;
            RU_PC:   rlines.nrpc  = 1'b0;
            RU_DR:   rlines.nrdr  = 1'b0;
            RU_AC:   rlines.nrac  = 1'b0;
            // codes 6 and 7 drive nothing
            default: rlines = RLINES_OFF;
         endcase
      end
   end

   ////////////////////////////////////////
   // write side
   ////////////////////////////////////////

   // strobes act as clock enables, sampled at the next clk5 edge
   always_comb begin
      wlines = WLINES_OFF;
      if (lines_on) begin
         case (ucode.wr)
            WU_AR:   wlines.nwar  = 1'b0;
            WU_PC:   wlines.nwpc  = 1'b0;
            WU_IR:   wlines.nwir  = 1'b0;
            WU_DR:   wlines.nwdr  = 1'b0;
            WU_AC:   wlines.nwac  = 1'b0;
            WU_ALU:  wlines.nwalu = 1'b0;
            default: wlines = WLINES_OFF;
         endcase
      end
   end

   // bus contention would show up as two enables at once
   a_one_reader: assert property (@(posedge clk5) disable iff (!rst_n)
      $onehot0(~rlines));

   a_one_writer: assert property (@(posedge clk5) disable iff (!rst_n)
      $onehot0(~wlines));

   // decoder outputs released while units are disabled
   a_nuce_idle: assert property (@(posedge clk5) disable iff (!rst_n)
      nuce |-> (rlines == RLINES_OFF) && (wlines == WLINES_OFF));

endmodule

// File: src/bus_registers.sv
////////////////////////////////////////
//
// bus registers
// AR, PC, IR, DR and AC loaded from the
// data bus, plus the paged AGL address
//
////////////////////////////////////////

module bus_registers
   import bus_pkg::*;
#(
   parameter int word_w = 16
) (
   input  logic               clk5,
   input  logic               rst_n,
   input  write_lines_t       wlines,
   input  logic [word_w-1:0]  dbus,
   output logic [word_w-1:0]  ar,
   output logic [word_w-1:0]  pc,
   output logic [word_w-1:0]  ir,
   output logic [word_w-1:0]  dr,
   output logic [word_w-1:0]  ac,
   output logic [word_w-1:0]  agl
);

   // the page field needs room above the offset
   if (word_w < 12) begin : g_width_check
      $error("bus_registers: word_w must be at least 12");
   end

   ////////////////////////////////////////
   // register file
   ////////////////////////////////////////

   // each register takes the bus value seen during the strobe cycle
   always_ff @(posedge clk5 or negedge rst_n) begin
      if (!rst_n) begin
         ar <= '0;
         pc <= '0;
         ir <= '0;
         dr <= '0;
         ac <= '0;
      end else begin
         // address register
         if (!wlines.nwar) begin
            ar <= dbus;
         end
         // program counter, no increment logic here
         if (!wlines.nwpc) begin
            pc <= dbus;
         end
         // instruction register
         if (!wlines.nwir) begin
            ir <= dbus;
         end
         // data register
         if (!wlines.nwdr) begin
            dr <= dbus;
         end
         // accumulator, also feeds the alu
         if (!wlines.nwac) begin
            ac <= dbus;
         end
      end
   end

   ////////////////////////////////////////
   // address generation
   ////////////////////////////////////////

   // page bits from the PC, offset from the instruction
   assign agl = {pc[word_w-1:AGL_OFFSET_W], ir[AGL_OFFSET_W-1:0]};

   // a register holds its value across any edge where its strobe was high
   property p_hold(logic nstrobe, logic [word_w-1:0] q);
      @(posedge clk5) disable iff (!rst_n)
         nstrobe |=> $stable(q);
   endproperty

   a_ar_hold: assert property (p_hold(wlines.nwar, ar));
   a_pc_hold: assert property (p_hold(wlines.nwpc, pc));
   a_ir_hold: assert property (p_hold(wlines.nwir, ir));
   a_dr_hold: assert property (p_hold(wlines.nwdr, dr));
   a_ac_hold: assert property (p_hold(wlines.nwac, ac));

endmodule

// File: src/alu_unit.sv
////////////////////////////////////////
//
// alu unit
// B operand latch and eight operations on
// AC and B, read through read codes 8 to 15
//
////////////////////////////////////////

module alu_unit
   import bus_pkg::*;
#(
   parameter int word_w = 16
) (
   input  logic               clk5,
   input  logic               rst_n,
   input  logic               nuce,
   input  logic               nwalu,
   input  read_field_u        ucode_rd,
   input  logic [word_w-1:0]  ac,
   input  logic [word_w-1:0]  dbus,
   output logic [word_w-1:0]  result,
   output logic               result_en
);

   // second operand, AC is the first
   logic [word_w-1:0] b_q;

   ////////////////////////////////////////
   // operand latch
   ////////////////////////////////////////

   always_ff @(posedge clk5 or negedge rst_n) begin
      if (!rst_n) begin
         b_q <= '0;
      end else if (!nwalu) begin
         b_q <= dbus;
      end
   end

   ////////////////////////////////////////
   // operations
   ////////////////////////////////////////

   // all results wrap to word_w bits
   always_comb begin
      case (ucode_rd.alu.op)
         OP_ADD:  result = ac + b_q;
         OP_SUB:  result = ac - b_q;
         OP_AND:  result = ac & b_q;
         OP_OR:   result = ac | b_q;
         OP_XOR:  result = ac ^ b_q;
         OP_NOT:  result = ~ac;
         // shifts only touch AC, zero filled
         OP_SHL:  result = ac << 1;
         OP_SHR:  result = ac >> 1;
         default: result = '0;
      endcase
   end

   // the alu owns the upper half of the read codes
   // so it decides its own read enable from the union flag
   assign result_en = ucode_rd.alu.alu && !nuce && rst_n;

endmodule

// File: src/data_bus.sv
////////////////////////////////////////
//
// data bus
// selects the one enabled source, reads
// all ones when nothing drives it
//
////////////////////////////////////////

module data_bus
   import bus_pkg::*;
#(
   parameter int word_w = 16
) (
   input  read_lines_t        rlines,
   input  logic [word_w-1:0]  ext_data,
   input  logic [word_w-1:0]  agl,
   input  logic [word_w-1:0]  pc,
   input  logic [word_w-1:0]  dr,
   input  logic [word_w-1:0]  ac,
   input  logic [word_w-1:0]  alu_result,
   input  logic               alu_en,
   output logic [word_w-1:0]  dbus
);

   // stands in for the tri-state drivers on a pulled-up bus
   always_comb begin
      // pull-ups win when the bus floats
      dbus = '1;
      if (alu_en) begin
         dbus = alu_result;
      end else if (!rlines.next) begin
         // testbench load port
         dbus = ext_data;
      end else if (!rlines.nragl) begin
         dbus = agl;
      end else if (!rlines.nrpc) begin
         dbus = pc;
      end else if (!rlines.nrdr) begin
         dbus = dr;
      end else if (!rlines.nrac) begin
         dbus = ac;
      end
   end

   // alu and decoder come from the same read field and must never overlap
   always_comb begin
      a_no_overlap: assert final (!alu_en || (rlines == RLINES_OFF))
         else $error("data_bus: alu and a register unit drive the bus together");
   end

endmodule

// File: src/processor_bus.sv
////////////////////////////////////////
//
// processor bus top level
// decoder, bus registers, alu and data bus
//
////////////////////////////////////////

module processor_bus
   import bus_pkg::*;
#(
   parameter int word_w = 16
) (
   input  logic               clk5,
   input  logic               rst_n,
   input  logic               nuce,
   input  micro_t             ucode,
   input  logic [word_w-1:0]  ext_data,
   output logic [word_w-1:0]  dbus,
   output logic [word_w-1:0]  ar,
   output logic [word_w-1:0]  pc,
   output logic [word_w-1:0]  ir,
   output logic [word_w-1:0]  dr,
   output logic [word_w-1:0]  ac,
   output read_lines_t        rlines,
   output write_lines_t       wlines
);

   // paged address from AGL
   logic [word_w-1:0] agl;
   // alu output and its bus enable
   logic [word_w-1:0] alu_result;
   logic              alu_en;

   unit_decoder u_unit_decoder (
      .clk5   (clk5),
      .rst_n  (rst_n),
      .nuce   (nuce),
      .ucode  (ucode),
      .rlines (rlines),
      .wlines (wlines)
   );

   bus_registers #(.word_w(word_w)) u_bus_registers (
      .clk5   (clk5),
      .rst_n  (rst_n),
      .wlines (wlines),
      .dbus   (dbus),
      .ar     (ar),
      .pc     (pc),
      .ir     (ir),
      .dr     (dr),
      .ac     (ac),
      .agl    (agl)
   );

   // the alu sees the read field directly, not the decoder lines
   alu_unit #(.word_w(word_w)) u_alu_unit (
      .clk5      (clk5),
      .rst_n     (rst_n),
      .nuce      (nuce),
      .nwalu     (wlines.nwalu),
      .ucode_rd  (ucode.rd),
      .ac        (ac),
      .dbus      (dbus),
      .result    (alu_result),
      .result_en (alu_en)
   );

   data_bus #(.word_w(word_w)) u_data_bus (
      .rlines     (rlines),
      .ext_data   (ext_data),
      .agl        (agl),
      .pc         (pc),
      .dr         (dr),
      .ac         (ac),
      .alu_result (alu_result),
      .alu_en     (alu_en),
      .dbus       (dbus)
   );

endmodule

// File: verif/tb_processor_bus.sv
////////////////////////////////////////
//
// processor bus testbench
// directed tests of the unit decoder, register
// transfers, alu, AGL and unit control enable
//
////////////////////////////////////////

module tb_processor_bus;
   import bus_pkg::*;

   localparam int WORD_W = 16;
   localparam int SEED   = 62030;

   // upper bounds of each test in clock cycles
   localparam int RESET_CYCLES  = 12;
   localparam int IDLE_CYCLES   = 2;
   localparam int XFER_CYCLES   = 18;
   localparam int LINE_CYCLES   = 27;
   localparam int ALU_CYCLES    = 15;
   localparam int AGL_CYCLES    = 6;
   localparam int NUCE_CYCLES   = 9;
   localparam int TEST_CYCLES   = RESET_CYCLES + IDLE_CYCLES + XFER_CYCLES + LINE_CYCLES
                                  + ALU_CYCLES + AGL_CYCLES + NUCE_CYCLES;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

   logic              clk5;
   logic              rst_n;
   logic              nuce;
   micro_t            ucode;
   logic [WORD_W-1:0] ext_data;
   logic [WORD_W-1:0] dbus;
   logic [WORD_W-1:0] ar;
   logic [WORD_W-1:0] pc;
   logic [WORD_W-1:0] ir;
   logic [WORD_W-1:0] dr;
   logic [WORD_W-1:0] ac;
   read_lines_t       rlines;
   write_lines_t      wlines;

   int check_count;
   int error_count;
   int cycle_count;

   processor_bus #(.word_w(WORD_W)) u_processor_bus (
      .clk5     (clk5),
      .rst_n    (rst_n),
      .nuce     (nuce),
      .ucode    (ucode),
      .ext_data (ext_data),
      .dbus     (dbus),
      .ar       (ar),
      .pc       (pc),
      .ir       (ir),
      .dr       (dr),
      .ac       (ac),
      .rlines   (rlines),
      .wlines   (wlines)
   );

   // 40 unit clock period
   initial begin
      clk5 = 1'b0;
      forever #20 clk5 = ~clk5;
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   // compare and log a mismatch
   task automatic compare(input string name, input logic [WORD_W-1:0] got,
                          input logic [WORD_W-1:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %s: got %h expected %h", name, got, exp);
      end
   endtask

   // new microinstruction on the falling edge, settle before checks
   task automatic apply_micro(input logic [3:0] rd_code, input logic [2:0] wr_code,
                              input logic [WORD_W-1:0] data);
      @(negedge clk5);
      ucode    = micro_t'({rd_code, wr_code});
      ext_data = data;
      #10;
   endtask

   task automatic set_enable(input logic value);
      @(negedge clk5);
      nuce = value;
   endtask

   function automatic logic [WORD_W-1:0] random_word();
      logic [31:0] r;
      r = $urandom;
      return r[WORD_W-1:0];
   endfunction

   // one-cold read pattern, order next nragl nrpc nrdr nrac
   function automatic logic [4:0] expected_rlines(input logic [3:0] code);
      case (code)
         4'd1:    return 5'b01111;
         4'd2:    return 5'b10111;
         4'd3:    return 5'b11011;
         4'd4:    return 5'b11101;
         4'd5:    return 5'b11110;
         default: return 5'b11111;
      endcase
   endfunction

   // one-cold write pattern, order nwar nwpc nwir nwdr nwac nwalu
   function automatic logic [5:0] expected_wlines(input logic [2:0] code);
      case (code)
         3'd2:    return 6'b011111;
         3'd3:    return 6'b101111;
         3'd4:    return 6'b110111;
         3'd5:    return 6'b111011;
         3'd6:    return 6'b111101;
         3'd7:    return 6'b111110;
         default: return 6'b111111;
      endcase
   endfunction

   // ac op b, wrapping at the word width
   function automatic logic [WORD_W-1:0] alu_reference(input logic [2:0] op,
         input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b);
      case (op)
         3'd0:    return a + b;
         3'd1:    return a - b;
         3'd2:    return a & b;
         3'd3:    return a | b;
         3'd4:    return a ^ b;
         3'd5:    return ~a;
         3'd6:    return {a[WORD_W-2:0], 1'b0};
         default: return {1'b0, a[WORD_W-1:1]};
      endcase
   endfunction

   // register value by write code
   function automatic logic [WORD_W-1:0] register_by_code(input logic [2:0] code);
      case (code)
         3'd2:    return ar;
         3'd3:    return pc;
         3'd4:    return ir;
         3'd5:    return dr;
         default: return ac;
      endcase
   endfunction

   // register name by write code
   function automatic string register_name(input logic [2:0] code);
      case (code)
         3'd2:    return "ar";
         3'd3:    return "pc";
         3'd4:    return "ir";
         3'd5:    return "dr";
         default: return "ac";
      endcase
   endfunction

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////

   task automatic reset_idle();
      // external read into AR while reset is still held
      apply_micro(4'd1, 3'd2, 16'h5a5a);
      compare("rlines", {11'd0, rlines}, 16'h001f);
      compare("wlines", {10'd0, wlines}, 16'h003f);
      compare("dbus", dbus, '1);
      // release reset together with an idle microinstruction
      @(negedge clk5);
      rst_n    = 1'b1;
      ucode    = '0;
      ext_data = '0;
      #10;
      compare("ar", ar, '0);
      compare("pc", pc, '0);
      compare("ir", ir, '0);
      compare("dr", dr, '0);
      compare("ac", ac, '0);
      compare("rlines", {11'd0, rlines}, 16'h001f);
      compare("wlines", {10'd0, wlines}, 16'h003f);
      // pull-ups with nothing driving
      compare("dbus", dbus, '1);
   endtask

   task automatic transfers();
      logic [WORD_W-1:0] loaded [2:6];
      logic [WORD_W-1:0] v;
      for (int w = 2; w <= 6; w++) begin
         v = random_word();
         loaded[w] = v;
         apply_micro(4'd1, w[2:0], v);
         compare("dbus", dbus, v);
         apply_micro(4'd0, 3'd0, '0);
         compare(register_name(w[2:0]), register_by_code(w[2:0]), v);
      end
      // PC into AR
      apply_micro(4'd3, 3'd2, '0);
      compare("dbus", dbus, loaded[3]);
      apply_micro(4'd0, 3'd0, '0);
      compare("ar", ar, loaded[3]);
      // DR into IR
      apply_micro(4'd4, 3'd4, '0);
      compare("dbus", dbus, loaded[5]);
      apply_micro(4'd0, 3'd0, '0);
      compare("ir", ir, loaded[5]);
      // AC into PC
      apply_micro(4'd5, 3'd3, '0);
      compare("dbus", dbus, loaded[6]);
      apply_micro(4'd0, 3'd0, '0);
      compare("pc", pc, loaded[6]);
   endtask

   task automatic decoder_lines();
      for (int r = 0; r < 16; r++) begin
         apply_micro(r[3:0], 3'd0, '0);
         compare("rlines", {11'd0, rlines}, {11'd0, expected_rlines(r[3:0])});
         compare("wlines", {10'd0, wlines}, 16'h003f);
      end
      // idle read, so every written unit picks up all ones
      for (int w = 0; w < 8; w++) begin
         apply_micro(4'd0, w[2:0], '0);
         compare("wlines", {10'd0, wlines}, {10'd0, expected_wlines(w[2:0])});
         compare("rlines", {11'd0, rlines}, 16'h001f);
      end
      apply_micro(4'd0, 3'd0, '0);
   endtask

   task automatic alu_operations();
      logic [WORD_W-1:0] a;
      logic [WORD_W-1:0] b;
      a = random_word();
      b = random_word();
      apply_micro(4'd1, 3'd6, a);
      apply_micro(4'd1, 3'd7, b);
      apply_micro(4'd0, 3'd0, '0);
      compare("ac", ac, a);
      for (int op = 0; op < 8; op++) begin
         apply_micro({1'b1, op[2:0]}, 3'd0, '0);
         compare("dbus", dbus, alu_reference(op[2:0], a, b));
         compare("rlines", {11'd0, rlines}, 16'h001f);
      end
      // sum written back into AC
      apply_micro(4'd8, 3'd6, '0);
      apply_micro(4'd0, 3'd0, '0);
      compare("ac", ac, alu_reference(3'd0, a, b));
   endtask

   task automatic agl_address();
      logic [WORD_W-1:0] p;
      logic [WORD_W-1:0] i;
      logic [WORD_W-1:0] page_addr;
      p = random_word();
      i = random_word();
      page_addr = {p[WORD_W-1:AGL_OFFSET_W], i[AGL_OFFSET_W-1:0]};
      apply_micro(4'd1, 3'd3, p);
      apply_micro(4'd1, 3'd4, i);
      // AGL onto the bus and into AR
      apply_micro(4'd2, 3'd2, '0);
      compare("dbus", dbus, page_addr);
      apply_micro(4'd0, 3'd0, '0);
      compare("ar", ar, page_addr);
   endtask

   task automatic unit_enable();
      logic [WORD_W-1:0] v;
      v = random_word();
      apply_micro(4'd1, 3'd5, v);
      apply_micro(4'd0, 3'd0, '0);
      compare("dr", dr, v);
      set_enable(1'b1);
      // write to DR while units are off
      apply_micro(4'd1, 3'd5, ~v);
      compare("rlines", {11'd0, rlines}, 16'h001f);
      compare("wlines", {10'd0, wlines}, 16'h003f);
      compare("dbus", dbus, '1);
      // alu is off as well
      apply_micro(4'd8, 3'd0, '0);
      compare("dbus", dbus, '1);
      apply_micro(4'd0, 3'd0, '0);
      compare("dr", dr, v);
      set_enable(1'b0);
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin
      rst_n       = 1'b0;
      nuce        = 1'b0;
      ucode       = '0;
      ext_data    = '0;
      check_count = 0;
      error_count = 0;
      void'($urandom(SEED));
      // reset_idle releases reset on the falling edge after the tenth cycle
      repeat (9) @(posedge clk5);
      reset_idle();
      transfers();
      decoder_lines();
      alu_operations();
      agl_address();
      unit_enable();
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // run limit, twice the summed test lengths
   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk5);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: filelist.f
src/bus_pkg.sv
src/unit_decoder.sv
src/bus_registers.sv
src/alu_unit.sv
src/data_bus.sv
src/processor_bus.sv
verif/tb_processor_bus.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the processor bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   --top-module tb_processor_bus \
   -f filelist.f \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Some tests failed" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
